// ==== sim.f ====
llc_pkg.sv
llc_input_decoder.sv
llc_ctrl.sv
llc_set_buffer.sv
llc_localmem.sv
llc_top.sv
tb_llc_mem_model.sv
tb_llc.sv

// ==== tb_llc.sv ====
`default_nettype none

module tb_llc;
    timeunit 1ns;
    timeprecision 1ps;
    import llc_pkg::*;

    localparam int WAIT_LIMIT = 500;

    typedef enum {K_READ, K_WRITE, K_FLUSH} stim_kind_t;

    // One table row with the response and the memory traffic it should cause.
    typedef struct packed {
        stim_kind_t kind;
        line_addr_t addr;
        line_t      wdata;
        line_t      exp_line;
        int         exp_wr;
        int         exp_rd;
        line_addr_t wb_addr;
        line_t      wb_line;
    } stim_t;

    logic     clk;
    logic     rst;
    llc_req_t req;
    logic     req_valid;
    logic     req_ready;
    llc_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;
    logic     mem_rsp_ready;
    logic     rst_tb_valid;
    logic     rst_tb_ready;
    logic     done_valid;
    logic     done_ready;
    int       mem_reads;
    int       mem_writes;
    mem_req_t last_wr;
    stim_t    stim_table[$];
    int       err_count;
    int       failed_tests;
    int       test_count;
    logic     timed_out;

    llc_top llc_top_inst (
        .clk(clk), .rst(rst),
        .req_i(req), .req_valid_i(req_valid), .req_ready_o(req_ready),
        .rsp_o(rsp), .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready),
        .mem_req_o(mem_req), .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
        .mem_rsp_i(mem_rsp), .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_ready_o(mem_rsp_ready),
        .rst_tb_valid_i(rst_tb_valid), .rst_tb_ready_o(rst_tb_ready),
        .rst_tb_done_valid_o(done_valid), .rst_tb_done_ready_i(done_ready)
    );

    tb_llc_mem_model mem_model_inst (
        .clk(clk), .rst(rst),
        .mem_req_i(mem_req), .mem_req_valid_i(mem_req_valid), .mem_req_ready_o(mem_req_ready),
        .mem_rsp_o(mem_rsp), .mem_rsp_valid_o(mem_rsp_valid), .mem_rsp_ready_i(mem_rsp_ready),
        .reads_o(mem_reads), .writes_o(mem_writes), .last_wr_o(last_wr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic line_t default_line(input line_addr_t addr);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*WORD_BITS +: WORD_BITS] = {4'h0, addr} ^ w;
        end
        return l;
    endfunction

    function automatic line_t write_line(input line_addr_t addr);
        return {4{4'hd, addr}};
    endfunction

    task automatic add_row(input stim_kind_t kind, input line_addr_t addr, input line_t exp_line,
                           input int exp_wr, input int exp_rd, input line_addr_t wb_addr);
        stim_t row;
        row.kind = kind;
        row.addr = addr;
        row.wdata = (kind == K_WRITE) ? write_line(addr) : '0;
        row.exp_line = exp_line;
        row.exp_wr = exp_wr;
        row.exp_rd = exp_rd;
        row.wb_addr = wb_addr;
        row.wb_line = write_line(wb_addr);
        stim_table.push_back(row);
    endtask

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        err_count++;
        timed_out = 1'b1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed", name);
            failed_tests++;
        end
    endtask

    task automatic send_req(input stim_t row);
        int n;
        @(posedge clk);
        req <= '{op: (row.kind == K_WRITE) ? REQ_WRITE : REQ_READ, addr: row.addr,
                 line: row.wdata};
        req_valid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_timeout("request ready");
            end
        end while (!req_ready && !timed_out);
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // Response ready toggles at random, so the held response is compared every cycle.
    task automatic wait_rsp(output llc_rsp_t got, output int lat);
        int   n;
        logic seen;
        logic done;
        n = 0;
        seen = 1'b0;
        done = 1'b0;
        got = '0;
        lat = 0;
        while (!done && !timed_out) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_timeout("a response");
            end
            check("req_ready_o", req_ready, 1'b0);
            if (rsp_valid) begin
                if (!seen) begin
                    got = rsp;
                    lat = n;
                    seen = 1'b1;
                end else begin
                    check("rsp_o", rsp, got);
                end
                done = rsp_ready;
            end else if (seen) begin
                $display("Response valid fell before the response was taken");
                err_count++;
                done = 1'b1;
            end
            @(posedge clk);
            rsp_ready <= ($urandom % 2) == 1;
        end
    endtask

    task automatic run_flush();
        int n;
        @(posedge clk);
        rst_tb_valid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_timeout("reset-flush command ready");
            end
        end while (!rst_tb_ready && !timed_out);
        @(posedge clk);
        rst_tb_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_timeout("reset-flush done");
            end
        end while (!done_valid && !timed_out);
    endtask

    // Set 5 holds the read and write cases, set 3 the round-robin eviction.
    task automatic build_table();
        add_row(K_FLUSH, '0, '0, 0, 0, '0);
        add_row(K_READ, 28'h15, default_line(28'h15), 0, 1, '0);
        add_row(K_READ, 28'h15, default_line(28'h15), 0, 0, '0);
        add_row(K_WRITE, 28'h25, '0, 0, 1, '0);
        add_row(K_READ, 28'h25, write_line(28'h25), 0, 0, '0);
        for (int k = 1; k <= 4; k++) begin
            add_row(K_WRITE, {24'(k), 4'h3}, '0, 0, 1, '0);
        end
        add_row(K_WRITE, 28'h53, '0, 1, 1, 28'h13);
        add_row(K_READ, 28'h13, write_line(28'h13), 1, 1, 28'h23);
        add_row(K_FLUSH, '0, '0, 0, 0, '0);
        add_row(K_READ, 28'h25, default_line(28'h25), 0, 1, '0);
    endtask

    initial begin
        stim_t    row;
        llc_rsp_t got;
        int       lat;
        int       rd0;
        int       wr0;
        int       errs0;
        string    test_name;
        void'($urandom(32'h9817_6cd3));
        rst = 1'b0;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        rst_tb_valid = 1'b0;
        done_ready = 1'b0;
        err_count = 0;
        failed_tests = 0;
        test_count = 0;
        timed_out = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        done_ready <= 1'b1;

        errs0 = err_count;
        @(posedge clk);
        req <= '{op: REQ_READ, addr: 28'h15, line: '0};
        req_valid <= 1'b1;
        repeat (10) begin
            @(negedge clk);
            check("req_ready_o", req_ready, 1'b0);
            check("rsp_valid_o", rsp_valid, 1'b0);
            check("mem_req_valid_o", mem_req_valid, 1'b0);
            check("rst_tb_done_valid_o", done_valid, 1'b0);
            check("rst_tb_ready_o", rst_tb_ready, 1'b1);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        report_test("request blocked before first reset-flush", errs0);

        foreach (stim_table[i]) begin
            row = stim_table[i];
            test_name = $sformatf("%0d %s %h", i, row.kind.name(), row.addr);
            errs0 = err_count;
            rd0 = mem_reads;
            wr0 = mem_writes;
            if (row.kind == K_FLUSH) begin
                run_flush();
            end else begin
                send_req(row);
                wait_rsp(got, lat);
            end
            if (timed_out) begin
                report_test(test_name, errs0);
                break;
            end
            if (row.kind != K_FLUSH) begin
                check("rsp_o.op", got.op, (row.kind == K_WRITE) ? REQ_WRITE : REQ_READ);
                check("rsp_o.addr", got.addr, row.addr);
                check("rsp_o.line", got.line, row.exp_line);
                if (row.exp_rd == 0 && row.exp_wr == 0) begin
                    check("hit latency", lat, 3);
                end
            end
            @(negedge clk);
            check("memory reads", mem_reads - rd0, row.exp_rd);
            check("memory writes", mem_writes - wr0, row.exp_wr);
            if (row.exp_wr > 0) begin
                check("mem_req_o.addr", last_wr.addr, row.wb_addr);
                check("mem_req_o.line", last_wr.line, row.wb_line);
            end
            report_test(test_name, errs0);
        end

        $display("%0d tests, %0d failed, %0d mismatches", test_count, failed_tests, err_count);
        if (!timed_out && err_count == 0 && failed_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_llc_mem_model.sv ====
`default_nettype none

module tb_llc_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  llc_pkg::mem_req_t mem_req_i,
    input  logic              mem_req_valid_i,
    output logic              mem_req_ready_o,
    output llc_pkg::mem_rsp_t mem_rsp_o,
    output logic              mem_rsp_valid_o,
    input  logic              mem_rsp_ready_i,
    output int                reads_o,
    output int                writes_o,
    output llc_pkg::mem_req_t last_wr_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import llc_pkg::*;

    line_t store [line_addr_t];
    logic  pending_q;
    int    delay_q;
    line_t pending_line_q;

    // Lines never written read back as the line address XOR the word index.
    function automatic line_t read_line(input line_addr_t addr);
        line_t l;
        if (store.exists(addr)) begin
            return store[addr];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*WORD_BITS +: WORD_BITS] = {4'h0, addr} ^ w;
        end
        return l;
    endfunction

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_req_ready_o <= 1'b0;
            mem_rsp_valid_o <= 1'b0;
            mem_rsp_o <= '0;
            reads_o <= 0;
            writes_o <= 0;
            last_wr_o <= '0;
            pending_q <= 1'b0;
            delay_q <= 0;
            pending_line_q <= '0;
        end else begin
            mem_req_ready_o <= ($urandom % 4) != 0;
            if (mem_req_valid_i && mem_req_ready_o) begin
                if (mem_req_i.write) begin
                    store[mem_req_i.addr] = mem_req_i.line;
                    writes_o <= writes_o + 1;
                    last_wr_o <= mem_req_i;
                end else begin
                    reads_o <= reads_o + 1;
                    pending_q <= 1'b1;
                    delay_q <= $urandom_range(0, 3);
                    pending_line_q <= read_line(mem_req_i.addr);
                end
            end
            if (mem_rsp_valid_o && mem_rsp_ready_i) begin
                mem_rsp_valid_o <= 1'b0;
            end
            if (pending_q) begin
                if (delay_q == 0) begin
                    mem_rsp_valid_o <= 1'b1;
                    mem_rsp_o.line <= pending_line_q;
                    pending_q <= 1'b0;
                end else begin
                    delay_q <= delay_q - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== llc_top.sv ====
`default_nettype none

module llc_top (
    input  logic              clk,
    input  logic              rst,
    input  llc_pkg::llc_req_t req_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    output llc_pkg::llc_rsp_t rsp_o,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output llc_pkg::mem_req_t mem_req_o,
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    input  llc_pkg::mem_rsp_t mem_rsp_i,
    input  logic              mem_rsp_valid_i,
    output logic              mem_rsp_ready_o,
    input  logic              rst_tb_valid_i,
    output logic              rst_tb_ready_o,
    output logic              rst_tb_done_valid_o,
    input  logic              rst_tb_done_ready_i
);
    import llc_pkg::*;

    llc_phase_t                phase;
    llc_req_t                  cur_req;
    logic                      is_rst_pass;
    logic                      pass_start;
    logic                      pass_done;
    logic                      flush_walk_done;
    logic                      hit;
    llc_way_t                  sel_way;
    way_entry_t                sel_entry;
    llc_way_t                  victim;
    logic                      buf_wr;
    way_entry_t                buf_wr_entry;
    llc_set_t                  mem_set;
    logic                      mem_rd;
    logic [LLC_WAYS-1:0]       mem_wr_mask;
    way_entry_t                mem_wr_entry;
    logic                      victim_wr;
    llc_way_t                  victim_wr_data;
    way_entry_t [LLC_WAYS-1:0] rd_ways;
    llc_way_t                  rd_victim;

    llc_input_decoder input_decoder_inst (
        .clk               (clk),
        .rst               (rst),
        .phase_i           (phase),
        .req_i             (req_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .rst_tb_valid_i    (rst_tb_valid_i),
        .rst_tb_ready_o    (rst_tb_ready_o),
        .pass_done_i       (pass_done),
        .flush_walk_done_i (flush_walk_done),
        .cur_req_o         (cur_req),
        .is_rst_pass_o     (is_rst_pass),
        .pass_start_o      (pass_start)
    );

    llc_ctrl ctrl_inst (
        .clk                 (clk),
        .rst                 (rst),
        .phase_o             (phase),
        .cur_req_i           (cur_req),
        .is_rst_pass_i       (is_rst_pass),
        .pass_start_i        (pass_start),
        .pass_done_o         (pass_done),
        .flush_walk_done_o   (flush_walk_done),
        .hit_i               (hit),
        .sel_way_i           (sel_way),
        .sel_entry_i         (sel_entry),
        .victim_i            (victim),
        .buf_wr_o            (buf_wr),
        .buf_wr_entry_o      (buf_wr_entry),
        .mem_set_o           (mem_set),
        .mem_rd_o            (mem_rd),
        .mem_wr_mask_o       (mem_wr_mask),
        .mem_wr_entry_o      (mem_wr_entry),
        .victim_wr_o         (victim_wr),
        .victim_wr_data_o    (victim_wr_data),
        .rsp_o               (rsp_o),
        .rsp_valid_o         (rsp_valid_o),
        .rsp_ready_i         (rsp_ready_i),
        .mem_req_o           (mem_req_o),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_ready_i     (mem_req_ready_i),
        .mem_rsp_i           (mem_rsp_i),
        .mem_rsp_valid_i     (mem_rsp_valid_i),
        .mem_rsp_ready_o     (mem_rsp_ready_o),
        .rst_tb_done_valid_o (rst_tb_done_valid_o),
        .rst_tb_done_ready_i (rst_tb_done_ready_i)
    );

    llc_set_buffer set_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .phase_i     (phase),
        .rd_ways_i   (rd_ways),
        .rd_victim_i (rd_victim),
        .cur_tag_i   (cur_req.addr[SET_BITS +: TAG_BITS]),
        .wr_i        (buf_wr),
        .wr_entry_i  (buf_wr_entry),
        .hit_o       (hit),
        .sel_way_o   (sel_way),
        .sel_entry_o (sel_entry),
        .victim_o    (victim)
    );

    llc_localmem localmem_inst (
        .clk              (clk),
        .rst              (rst),
        .set_i            (mem_set),
        .rd_i             (mem_rd),
        .wr_mask_i        (mem_wr_mask),
        .wr_entry_i       (mem_wr_entry),
        .victim_wr_i      (victim_wr),
        .victim_wr_data_i (victim_wr_data),
        .rd_ways_o        (rd_ways),
        .rd_victim_o      (rd_victim)
    );

endmodule

`default_nettype wire

// ==== llc_localmem.sv ====
`default_nettype none

module llc_localmem (
    input  logic                                      clk,
    input  logic                                      rst,
    input  llc_pkg::llc_set_t                         set_i,
    input  logic                                      rd_i,
    input  logic [llc_pkg::LLC_WAYS-1:0]              wr_mask_i,
    input  llc_pkg::way_entry_t                       wr_entry_i,
    input  logic                                      victim_wr_i,
    input  llc_pkg::llc_way_t                         victim_wr_data_i,
    output llc_pkg::way_entry_t [llc_pkg::LLC_WAYS-1:0] rd_ways_o,
    output llc_pkg::llc_way_t                         rd_victim_o
);
    import llc_pkg::*;

    llc_tag_t tag_mem   [LLC_WAYS][LLC_SETS];
    logic     valid_mem [LLC_WAYS][LLC_SETS];
    logic     dirty_mem [LLC_WAYS][LLC_SETS];
    line_t    line_mem  [LLC_WAYS][LLC_SETS];
    llc_way_t victim_mem [LLC_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (wr_mask_i[w]) begin
                tag_mem[w][set_i] <= wr_entry_i.tag;
                valid_mem[w][set_i] <= wr_entry_i.valid;
                dirty_mem[w][set_i] <= wr_entry_i.dirty;
                line_mem[w][set_i] <= wr_entry_i.line;
            end
            if (rd_i) begin
                rd_ways_o[w].tag <= tag_mem[w][set_i];
                rd_ways_o[w].valid <= valid_mem[w][set_i];
                rd_ways_o[w].dirty <= dirty_mem[w][set_i];
                rd_ways_o[w].line <= line_mem[w][set_i];
            end
        end
        if (rd_i) begin
            rd_victim_o <= victim_mem[set_i];
        end
    end

    // Round-robin pointers start at way 0 in every set.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < LLC_SETS; s++) begin
                victim_mem[s] <= '0;
            end
        end else if (victim_wr_i) begin
            victim_mem[set_i] <= victim_wr_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== llc_set_buffer.sv ====
`default_nettype none

module llc_set_buffer (
    input  logic                                      clk,
    input  logic                                      rst,
    input  llc_pkg::llc_phase_t                       phase_i,
    input  llc_pkg::way_entry_t [llc_pkg::LLC_WAYS-1:0] rd_ways_i,
    input  llc_pkg::llc_way_t                         rd_victim_i,
    input  llc_pkg::llc_tag_t                         cur_tag_i,
    input  logic                                      wr_i,
    input  llc_pkg::way_entry_t                       wr_entry_i,
    output logic                                      hit_o,
    output llc_pkg::llc_way_t                         sel_way_o,
    output llc_pkg::way_entry_t                       sel_entry_o,
    output llc_pkg::llc_way_t                         victim_o
);
    import llc_pkg::*;

    way_entry_t [LLC_WAYS-1:0] ways_q;
    logic                      hit_q;
    llc_way_t                  sel_way_q;
    llc_way_t                  victim_q;
    logic                      hit_c;
    llc_way_t                  hit_way_c;

    always_comb begin
        hit_c = 1'b0;
        hit_way_c = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (!hit_c && rd_ways_i[w].valid && rd_ways_i[w].tag == cur_tag_i) begin
                hit_c = 1'b1;
                hit_way_c = llc_way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase_i == PH_LOOKUP) begin
            ways_q <= rd_ways_i;
        end else if (wr_i) begin
            ways_q[sel_way_q] <= wr_entry_i;
        end
    end

    // On a miss the selected way is the victim.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_q <= 1'b0;
            sel_way_q <= '0;
            victim_q <= '0;
        end else if (phase_i == PH_LOOKUP) begin
            hit_q <= hit_c;
            sel_way_q <= hit_c ? hit_way_c : rd_victim_i;
            victim_q <= rd_victim_i;
        end
    end

    assign hit_o = hit_q;
    assign sel_way_o = sel_way_q;
    assign sel_entry_o = ways_q[sel_way_q];
    assign victim_o = victim_q;

endmodule

`default_nettype wire

// ==== llc_ctrl.sv ====
`default_nettype none

module llc_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    output llc_pkg::llc_phase_t           phase_o,
    input  llc_pkg::llc_req_t             cur_req_i,
    input  logic                          is_rst_pass_i,
    input  logic                          pass_start_i,
    output logic                          pass_done_o,
    output logic                          flush_walk_done_o,
    input  logic                          hit_i,
    input  llc_pkg::llc_way_t             sel_way_i,
    input  llc_pkg::way_entry_t           sel_entry_i,
    input  llc_pkg::llc_way_t             victim_i,
    output logic                          buf_wr_o,
    output llc_pkg::way_entry_t           buf_wr_entry_o,
    output llc_pkg::llc_set_t             mem_set_o,
    output logic                          mem_rd_o,
    output logic [llc_pkg::LLC_WAYS-1:0]  mem_wr_mask_o,
    output llc_pkg::way_entry_t           mem_wr_entry_o,
    output logic                          victim_wr_o,
    output llc_pkg::llc_way_t             victim_wr_data_o,
    output llc_pkg::llc_rsp_t             rsp_o,
    output logic                          rsp_valid_o,
    input  logic                          rsp_ready_i,
    output llc_pkg::mem_req_t             mem_req_o,
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    input  llc_pkg::mem_rsp_t             mem_rsp_i,
    input  logic                          mem_rsp_valid_i,
    output logic                          mem_rsp_ready_o,
    output logic                          rst_tb_done_valid_o,
    input  logic                          rst_tb_done_ready_i
);
    import llc_pkg::*;

    // Steps of a request inside PH_PROCESS.
    typedef enum logic [2:0] {
        S_CHECK,
        S_WB,
        S_FETCH,
        S_WAIT,
        S_RSP
    } proc_step_t;

    llc_phase_t phase_q;
    llc_phase_t phase_d;
    proc_step_t step_q;
    proc_step_t step_d;
    llc_set_t   flush_set_q;
    llc_set_t   cur_set;
    llc_tag_t   cur_tag;
    logic       req_process;
    logic       rsp_fire;
    logic       mem_req_fire;
    logic       mem_rsp_fire;
    logic       done_valid_q;

    assign phase_o = phase_q;
    assign cur_set = cur_req_i.addr[SET_BITS-1:0];
    assign cur_tag = cur_req_i.addr[SET_BITS +: TAG_BITS];

    assign req_process = (phase_q == PH_PROCESS) && !is_rst_pass_i;
    assign rsp_valid_o = req_process && ((step_q == S_CHECK && hit_i) || step_q == S_RSP);
    assign mem_req_valid_o = req_process && (step_q == S_WB || step_q == S_FETCH);
    assign mem_rsp_ready_o = req_process && (step_q == S_WAIT);

    assign rsp_fire = rsp_valid_o && rsp_ready_i;
    assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
    assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_DECODE: begin
                if (pass_start_i) begin
                    phase_d = PH_READ;
                end
            end
            PH_READ:    phase_d = PH_LOOKUP;
            PH_LOOKUP:  phase_d = PH_PROCESS;
            PH_PROCESS: begin
                if (is_rst_pass_i || rsp_fire) begin
                    phase_d = PH_UPDATE;
                end
            end
            default:    phase_d = PH_DECODE;
        endcase
    end

    // A miss writes back a dirty victim, then fetches the line, then answers.
    always_comb begin
        step_d = step_q;
        if (req_process) begin
            case (step_q)
                S_CHECK: begin
                    if (!hit_i) begin
                        step_d = (sel_entry_i.valid && sel_entry_i.dirty) ? S_WB : S_FETCH;
                    end
                end
                S_WB: begin
                    if (mem_req_fire) begin
                        step_d = S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (mem_req_fire) begin
                        step_d = S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem_rsp_fire) begin
                        step_d = S_RSP;
                    end
                end
                default: begin
                    if (rsp_fire) begin
                        step_d = S_CHECK;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase_q <= PH_DECODE;
            step_q <= S_CHECK;
            flush_set_q <= '0;
            done_valid_q <= 1'b0;
        end else begin
            phase_q <= phase_d;
            step_q <= step_d;
            if (phase_q == PH_UPDATE && is_rst_pass_i) begin
                flush_set_q <= flush_set_q + llc_set_t'(1);
            end
            if (phase_q == PH_UPDATE && flush_walk_done_o) begin
                done_valid_q <= 1'b1;
            end else if (rst_tb_done_ready_i) begin
                done_valid_q <= 1'b0;
            end
        end
    end

    assign pass_done_o = (phase_q == PH_UPDATE);
    assign flush_walk_done_o = is_rst_pass_i && (flush_set_q == llc_set_t'(LLC_SETS - 1));
    assign rst_tb_done_valid_o = done_valid_q;

    always_comb begin
        rsp_o.op = cur_req_i.op;
        rsp_o.addr = cur_req_i.addr;
        rsp_o.line = (cur_req_i.op == REQ_READ) ? sel_entry_i.line : '0;

        mem_req_o.write = (step_q == S_WB);
        mem_req_o.addr = (step_q == S_WB) ? {sel_entry_i.tag, cur_set} : cur_req_i.addr;
        mem_req_o.line = (step_q == S_WB) ? sel_entry_i.line : '0;

        // The fetched line lands clean. A write then overwrites it as dirty.
        buf_wr_o = mem_rsp_fire || (rsp_fire && cur_req_i.op == REQ_WRITE);
        buf_wr_entry_o.tag = cur_tag;
        buf_wr_entry_o.valid = 1'b1;
        buf_wr_entry_o.dirty = !mem_rsp_fire;
        buf_wr_entry_o.line = mem_rsp_fire ? mem_rsp_i.line : cur_req_i.line;
    end

    assign mem_set_o = is_rst_pass_i ? flush_set_q : cur_set;
    assign mem_rd_o = (phase_q == PH_READ);

    always_comb begin
        mem_wr_mask_o = '0;
        if (phase_q == PH_UPDATE) begin
            if (is_rst_pass_i) begin
                mem_wr_mask_o = '1;
            end else begin
                mem_wr_mask_o[sel_way_i] = 1'b1;
            end
        end
    end

    assign mem_wr_entry_o = is_rst_pass_i ? '0 : sel_entry_i;

    // The victim pointer moves on only after a miss filled the victim way.
    assign victim_wr_o = (phase_q == PH_UPDATE) && (is_rst_pass_i || !hit_i);
    assign victim_wr_data_o = is_rst_pass_i ? '0 : victim_i + llc_way_t'(1);

endmodule

`default_nettype wire

// ==== llc_input_decoder.sv ====
`default_nettype none

module llc_input_decoder (
    input  logic                clk,
    input  logic                rst,
    input  llc_pkg::llc_phase_t phase_i,
    input  llc_pkg::llc_req_t   req_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  logic                rst_tb_valid_i,
    output logic                rst_tb_ready_o,
    input  logic                pass_done_i,
    input  logic                flush_walk_done_i,
    output llc_pkg::llc_req_t   cur_req_o,
    output logic                is_rst_pass_o,
    output logic                pass_start_o
);
    import llc_pkg::*;

    logic decode_en;
    logic need_flush_q;
    logic rst_pass_q;
    logic cmd_fire;
    logic req_fire;

    assign decode_en = (phase_i == PH_DECODE);

    // A pending reset-flush command wins over a request in the same cycle.
    assign rst_tb_ready_o = decode_en;
    assign req_ready_o = decode_en && !need_flush_q && !rst_pass_q && !rst_tb_valid_i;

    assign cmd_fire = rst_tb_valid_i && rst_tb_ready_o;
    assign req_fire = req_valid_i && req_ready_o;

    // Once a walk has begun, every pass is a flush pass until the last set is done.
    assign pass_start_o = decode_en && (rst_pass_q || cmd_fire || req_fire);
    assign is_rst_pass_o = rst_pass_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            need_flush_q <= 1'b1;
            rst_pass_q <= 1'b0;
        end else if (pass_done_i && flush_walk_done_i) begin
            need_flush_q <= 1'b0;
            rst_pass_q <= 1'b0;
        end else if (cmd_fire) begin
            rst_pass_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            cur_req_o <= req_i;
        end
    end

endmodule

`default_nettype wire

// ==== llc_pkg.sv ====
`default_nettype none

package llc_pkg;

    localparam int LLC_WAYS = 4;
    localparam int LLC_SETS = 16;
    localparam int SET_BITS = 4;
    localparam int TAG_BITS = 24;
    localparam int WORD_BITS = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int WAY_BITS = 2;
    localparam int LINE_BITS = WORD_BITS * WORDS_PER_LINE;

    // A line address is the tag on top of the set index.
    typedef logic [TAG_BITS+SET_BITS-1:0] line_addr_t;
    typedef logic [SET_BITS-1:0]          llc_set_t;
    typedef logic [TAG_BITS-1:0]          llc_tag_t;
    typedef logic [WAY_BITS-1:0]          llc_way_t;
    typedef logic [LINE_BITS-1:0]         line_t;

    typedef enum logic {
        REQ_READ,
        REQ_WRITE
    } req_op_t;

    typedef struct packed {
        req_op_t    op;
        line_addr_t addr;
        line_t      line;
    } llc_req_t;

    // The line is zero when a write is acknowledged.
    typedef struct packed {
        req_op_t    op;
        line_addr_t addr;
        line_t      line;
    } llc_rsp_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      line;
    } mem_req_t;

    typedef struct packed {
        line_t line;
    } mem_rsp_t;

    typedef struct packed {
        llc_tag_t tag;
        logic     valid;
        logic     dirty;
        line_t    line;
    } way_entry_t;

    typedef enum logic [2:0] {
        PH_DECODE,
        PH_READ,
        PH_LOOKUP,
        PH_PROCESS,
        PH_UPDATE
    } llc_phase_t;

endpackage

`default_nettype wire
